// ==== z1top_pkg.sv ====
package z1top_pkg;

    // UART byte and board LED widths
    localparam int data_width = 8;
    localparam int led_width = 6;

    // A received byte is either a plain character or an LED command
    typedef union packed {
        logic [data_width-1:0] ascii;
        struct packed {
            logic                 is_cmd;
            logic                 spare;
            logic [led_width-1:0] led_value;
        } cmd;
    } rx_word_u;

    // Sent when button 1 is pressed
    localparam logic [data_width-1:0] char_star = 8'h2a;

    // Upper and lower case letters differ only in this bit
    localparam int case_bit = 5;

endpackage

// ==== tick_timer.sv ====
`timescale 1ns/1ns

module tick_timer #(
    parameter int PERIOD = 25_000
) (
    input  logic cpu_clk,
    input  logic rst_n,
    output logic tick
);
    localparam int cnt_w = (PERIOD > 1) ? $clog2(PERIOD) : 1;
    localparam logic [cnt_w-1:0] reload = cnt_w'(PERIOD - 1);

    logic [cnt_w-1:0] count;

    // Down-counter, one tick per reload
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= reload;
            tick  <= 1'b0;
        end else if (count == '0) begin
            count <= reload;
            tick  <= 1'b1;
        end else begin
            count <= count - 1'b1;
            tick  <= 1'b0;
        end
    end

    // The debounce counters rely on tick being a single-cycle strobe
    tick_is_strobe: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        tick |=> !tick)
        else $error("tick_timer: tick high on two consecutive cycles");

endmodule

// ==== button_parser.sv ====
`timescale 1ns/1ns

module button_parser #(
    parameter int WIDTH = 4,
    parameter int SAMPLE_CNT_MAX = 25_000,
    parameter int PULSE_CNT_MAX = 200
) (
    input  logic             cpu_clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] buttons,
    input  logic [1:0]       switches,
    output logic [WIDTH-1:0] buttons_pressed,
    output logic [1:0]       switches_sync
);
    localparam int sync_w = WIDTH + 2;
    localparam int pulse_w = $clog2(PULSE_CNT_MAX + 1);
    localparam logic [pulse_w-1:0] pulse_max = pulse_w'(PULSE_CNT_MAX);

    logic [sync_w-1:0]  sync_meta;
    logic [sync_w-1:0]  sync_q;
    logic [WIDTH-1:0]   buttons_sync;
    logic               sample_tick;
    logic [pulse_w-1:0] pulse_cnt [WIDTH];
    logic [WIDTH-1:0]   debounced;
    logic [WIDTH-1:0]   debounced_q;

    // Buttons and switches go through the same two-flop synchronizer
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
        end else begin
            sync_meta <= {switches, buttons};
            sync_q    <= sync_meta;
        end
    end

    assign buttons_sync  = sync_q[WIDTH-1:0];
    assign switches_sync = sync_q[WIDTH +: 2];

    tick_timer #(
        .PERIOD(SAMPLE_CNT_MAX)
    ) u_sample_timer (
        .cpu_clk(cpu_clk),
        .rst_n  (rst_n),
        .tick   (sample_tick)
    );

    // Count consecutive pressed samples, saturate at the max,
    // any released sample starts over
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < WIDTH; i++) begin
                pulse_cnt[i] <= '0;
            end
        end else if (sample_tick) begin
            for (int i = 0; i < WIDTH; i++) begin
                if (!buttons_sync[i]) begin
                    pulse_cnt[i] <= '0;
                end else if (pulse_cnt[i] != pulse_max) begin
                    pulse_cnt[i] <= pulse_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            debounced[i] = (pulse_cnt[i] == pulse_max);
        end
    end

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            debounced_q <= '0;
        end else begin
            debounced_q <= debounced;
        end
    end

    // Rising edge of the debounced level
    assign buttons_pressed = debounced & ~debounced_q;

    // A held button must produce a single pulse, not a level
    press_is_pulse: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        (buttons_pressed & $past(buttons_pressed)) == '0)
        else $error("button_parser: press pulse longer than one cycle");

endmodule

// ==== uart_receiver.sv ====
`timescale 1ns/1ns

module uart_receiver #(
    parameter int CPU_CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic                            cpu_clk,
    input  logic                            rst_n,
    input  logic                            serial_in,
    output logic [z1top_pkg::data_width-1:0] rx_data,
    output logic                            rx_valid
);
    import z1top_pkg::*;

    localparam int clks_per_bit = CPU_CLOCK_FREQ / BAUD_RATE;
    localparam int baud_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [baud_w-1:0] bit_reload = baud_w'(clks_per_bit - 1);
    localparam logic [baud_w-1:0] half_reload = baud_w'(clks_per_bit / 2 - 1);
    localparam int idx_w = $clog2(data_width);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;
    logic [1:0]            state;
    logic [baud_w-1:0]     baud_cnt;
    logic [idx_w-1:0]      bit_idx;
    logic [data_width-1:0] shift_reg;
    logic                  start_edge;
    logic                  baud_done;

    // Line idles high, so the synchronizer resets to one
    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= serial_in;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev && !rx_sync;
    assign baud_done  = (baud_cnt == '0);

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (state != st_idle && !baud_done) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                case (state)
                    st_idle: begin
                        // Wait half a bit to land in the middle of the start bit
                        if (start_edge) begin
                            state    <= st_start;
                            baud_cnt <= half_reload;
                        end
                    end
                    st_start: begin
                        // A short low glitch is not a start bit
                        state    <= rx_sync ? st_idle : st_data;
                        baud_cnt <= bit_reload;
                        bit_idx  <= '0;
                    end
                    st_data: begin
                        baud_cnt <= bit_reload;
                        if (bit_idx == idx_w'(data_width - 1)) begin
                            state <= st_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                    default: begin
                        // Framing error drops the byte silently
                        rx_valid <= rx_sync;
                        state    <= st_idle;
                    end
                endcase
            end
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge cpu_clk) begin
        if (state == st_data && baud_done) begin
            shift_reg <= {rx_sync, shift_reg[data_width-1:1]};
        end
    end

    assign rx_data = shift_reg;

endmodule

// ==== uart_transmitter.sv ====
`timescale 1ns/1ns

module uart_transmitter #(
    parameter int CPU_CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic                            cpu_clk,
    input  logic                            rst_n,
    input  logic [z1top_pkg::data_width-1:0] tx_data,
    input  logic                            tx_start,
    output logic                            tx_ready,
    output logic                            serial_out
);
    import z1top_pkg::*;

    localparam int clks_per_bit = CPU_CLOCK_FREQ / BAUD_RATE;
    localparam int baud_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [baud_w-1:0] bit_reload = baud_w'(clks_per_bit - 1);
    // Start bit, data bits, stop bit
    localparam int frame_w = data_width + 2;
    localparam int bit_w = $clog2(frame_w);

    logic               busy;
    logic               launch;
    logic               baud_done;
    logic [baud_w-1:0]  baud_cnt;
    logic [bit_w-1:0]   bit_cnt;
    logic [frame_w-1:0] frame;

    assign launch    = tx_start && !busy;
    assign baud_done = (baud_cnt == '0);

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (launch) begin
            busy     <= 1'b1;
            baud_cnt <= bit_reload;
            bit_cnt  <= '0;
        end else if (busy) begin
            if (!baud_done) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else if (bit_cnt == bit_w'(frame_w - 1)) begin
                // End of the stop bit
                busy <= 1'b0;
            end else begin
                bit_cnt  <= bit_cnt + 1'b1;
                baud_cnt <= bit_reload;
            end
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (launch) begin
            frame <= {1'b1, tx_data, 1'b0};
        end else if (busy && baud_done) begin
            frame <= {1'b1, frame[frame_w-1:1]};
        end
    end

    assign serial_out = busy ? frame[0] : 1'b1;
    assign tx_ready   = !busy;

    // A start while a frame is on the line would be lost
    start_when_ready: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        tx_start |-> tx_ready)
        else $error("uart_transmitter: tx_start while busy");

endmodule

// ==== echo_controller.sv ====
`timescale 1ns/1ns

module echo_controller (
    input  logic                            cpu_clk,
    input  logic                            rst_n,
    input  logic [z1top_pkg::data_width-1:0] rx_data,
    input  logic                            rx_valid,
    input  logic [3:0]                      buttons_pressed,
    input  logic [1:0]                      switches_sync,
    input  logic                            tx_ready,
    output logic [z1top_pkg::data_width-1:0] tx_data,
    output logic                            tx_start,
    output logic [z1top_pkg::led_width-1:0]  leds
);
    import z1top_pkg::*;

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_pending = 2'd1;
    localparam logic [1:0] st_send    = 2'd2;
    localparam logic [data_width-1:0] flip_mask = data_width'(1) << case_bit;

    logic [1:0]            state;
    rx_word_u              rx_word;
    logic [data_width-1:0] lower_char;
    logic                  is_letter;
    logic                  queue_req;
    logic [data_width-1:0] queue_byte;

    assign rx_word    = rx_data;
    assign lower_char = rx_word.ascii | flip_mask;
    assign is_letter  = (lower_char >= "a") && (lower_char <= "z");

    // A received character outranks a button-1 press in the same cycle
    always_comb begin
        queue_req  = 1'b0;
        queue_byte = rx_word.ascii;
        if (rx_valid) begin
            if (!rx_word.cmd.is_cmd && !switches_sync[1]) begin
                queue_req = 1'b1;
                if (switches_sync[0] && is_letter) begin
                    queue_byte = rx_word.ascii ^ flip_mask;
                end
            end
        end else if (buttons_pressed[1]) begin
            queue_req  = 1'b1;
            queue_byte = char_star;
        end
    end

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (queue_req) state <= tx_ready ? st_send : st_pending;
                // Transmitter goes busy on the next edge, so hold any new byte
                st_send: state <= queue_req ? st_pending : st_idle;
                default: if (tx_ready) state <= st_send;
            endcase
        end
    end

    // tx_data doubles as the one-byte pending buffer
    always_ff @(posedge cpu_clk) begin
        if (queue_req && state != st_pending) begin
            tx_data <= queue_byte;
        end
    end

    assign tx_start = (state == st_send);

    always_ff @(posedge cpu_clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (rx_valid && (rx_word.cmd.is_cmd || switches_sync[1])) begin
            leds <= rx_word.cmd.led_value;
        end else if (buttons_pressed[0]) begin
            leds <= '0;
        end
    end

    // The ready level seen one cycle earlier must still hold at the start
    start_needs_ready: assert property (@(posedge cpu_clk) disable iff (!rst_n)
        tx_start |-> tx_ready)
        else $error("echo_controller: tx_start issued while transmitter busy");

endmodule

// ==== z1top.sv ====
`timescale 1ns/1ns

module z1top #(
    parameter int CPU_CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE = 115_200,
    // Sample the buttons every 500 us
    parameter int B_SAMPLE_CNT_MAX = 25_000,
    // 100 ms of steady press at that sample rate
    parameter int B_PULSE_CNT_MAX = 200
) (
    input  logic                           cpu_clk,
    input  logic                           rst_n,
    input  logic [3:0]                     BUTTONS,
    input  logic [1:0]                     SWITCHES,
    output logic [z1top_pkg::led_width-1:0] LEDS,
    input  logic                           FPGA_SERIAL_RX,
    output logic                           FPGA_SERIAL_TX
);
    import z1top_pkg::*;

    logic [3:0]            buttons_pressed;
    logic [1:0]            switches_sync;
    logic [data_width-1:0] rx_data;
    logic                  rx_valid;
    logic [data_width-1:0] tx_data;
    logic                  tx_start;
    logic                  tx_ready;

    button_parser #(
        .WIDTH         (4),
        .SAMPLE_CNT_MAX(B_SAMPLE_CNT_MAX),
        .PULSE_CNT_MAX (B_PULSE_CNT_MAX)
    ) u_bp (
        .cpu_clk        (cpu_clk),
        .rst_n          (rst_n),
        .buttons        (BUTTONS),
        .switches       (SWITCHES),
        .buttons_pressed(buttons_pressed),
        .switches_sync  (switches_sync)
    );

    uart_receiver #(
        .CPU_CLOCK_FREQ(CPU_CLOCK_FREQ),
        .BAUD_RATE     (BAUD_RATE)
    ) u_uart_rx (
        .cpu_clk  (cpu_clk),
        .rst_n    (rst_n),
        .serial_in(FPGA_SERIAL_RX),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_transmitter #(
        .CPU_CLOCK_FREQ(CPU_CLOCK_FREQ),
        .BAUD_RATE     (BAUD_RATE)
    ) u_uart_tx (
        .cpu_clk   (cpu_clk),
        .rst_n     (rst_n),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx_ready  (tx_ready),
        .serial_out(FPGA_SERIAL_TX)
    );

    // Sits where the CPU would be
    echo_controller u_echo (
        .cpu_clk        (cpu_clk),
        .rst_n          (rst_n),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .buttons_pressed(buttons_pressed),
        .switches_sync  (switches_sync),
        .tx_ready       (tx_ready),
        .tx_data        (tx_data),
        .tx_start       (tx_start),
        .leds           (LEDS)
    );

endmodule

// ==== z1top_tb.sv ====
`timescale 1ns/1ns

module z1top_tb;
    import z1top_pkg::*;

    // Small DUT settings, eight cycles per bit
    localparam int clk_freq = 1_000_000;
    localparam int baud_rate = 125_000;
    localparam int sample_cnt = 4;
    localparam int pulse_cnt = 3;

    localparam int bit_cycles = clk_freq / baud_rate;
    localparam int frame_cycles = 10 * bit_cycles;
    localparam int frame_wait = 3 * frame_cycles;
    localparam int quiet_cycles = frame_cycles + 5 * bit_cycles;
    // Saturates the press counter from any tick phase
    localparam int press_cycles = 2 * (pulse_cnt + 2) * sample_cnt;
    // Spans exactly one sample tick fewer than a press needs
    localparam int glitch_cycles = (pulse_cnt - 1) * sample_cnt;
    localparam int row_budget = 6 * frame_cycles;

    localparam int act_wait = 0;
    localparam int act_send = 1;
    localparam int act_press = 2;
    localparam int act_glitch = 3;
    localparam int act_switch = 4;
    localparam int act_pair = 5;
    localparam int act_drop = 6;

    typedef struct {
        string       name;
        int          action;
        logic [15:0] value;
    } stim_t;

    logic                  cpu_clk = 1'b0;
    logic                  rst_n;
    logic [3:0]            buttons;
    logic [1:0]            switches;
    logic [led_width-1:0]  leds;
    logic                  serial_rx;
    logic                  serial_tx;

    stim_t                 rows[$];
    logic [data_width-1:0] exp_q[$];
    logic [data_width-1:0] got_q[$];
    logic [led_width-1:0]  model_leds;
    logic [1:0]            model_sw;
    int                    cycles = 0;
    int                    cycle_limit = 0;
    int                    errors = 0;
    int                    tests_failed = 0;

    z1top #(
        .CPU_CLOCK_FREQ  (clk_freq),
        .BAUD_RATE       (baud_rate),
        .B_SAMPLE_CNT_MAX(sample_cnt),
        .B_PULSE_CNT_MAX (pulse_cnt)
    ) u_dut (
        .cpu_clk       (cpu_clk),
        .rst_n         (rst_n),
        .BUTTONS       (buttons),
        .SWITCHES      (switches),
        .LEDS          (leds),
        .FPGA_SERIAL_RX(serial_rx),
        .FPGA_SERIAL_TX(serial_tx)
    );

    always #5 cpu_clk = ~cpu_clk;

    always @(posedge cpu_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("ERROR run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ASCII letter ranges A..Z and a..z
    function automatic bit is_letter(input logic [7:0] c);
        return (c >= 8'h41 && c <= 8'h5a) || (c >= 8'h61 && c <= 8'h7a);
    endfunction

    function automatic logic [7:0] rand_char();
        return 8'($urandom) & 8'h7f;
    endfunction

    task automatic add_row(input string name, input int action, input logic [15:0] value);
        stim_t row;
        row.name = name;
        row.action = action;
        row.value = value;
        rows.push_back(row);
    endtask

    task automatic build_table();
        add_row("reset_idle", act_wait, 16'h0000);
        add_row("echo_upper", act_send, 16'h0041);
        add_row("echo_lower", act_send, 16'h007a);
        add_row("echo_digit", act_send, 16'h0037);
        for (int i = 0; i < 4; i++) begin
            add_row($sformatf("echo_rand_%0d", i), act_send, {8'h00, rand_char()});
        end
        add_row("sw0_set", act_switch, 16'h0001);
        add_row("flip_upper", act_send, 16'h0051);
        add_row("flip_lower", act_send, 16'h006d);
        // Neighbours of the letter ranges stay as they are
        add_row("flip_at", act_send, 16'h0040);
        add_row("flip_brace", act_send, 16'h007b);
        for (int i = 0; i < 2; i++) begin
            add_row($sformatf("flip_rand_%0d", i), act_send, {8'h00, rand_char()});
        end
        add_row("sw1_set", act_switch, 16'h0002);
        add_row("sw1_char", act_send, 16'h006b);
        add_row("sw_clear", act_switch, 16'h0000);
        add_row("led_cmd_a", act_send, 16'h00a5);
        add_row("led_cmd_b", act_send, 16'h00ff);
        add_row("btn0_clear", act_press, 16'h0000);
        add_row("btn1_star", act_press, 16'h0001);
        add_row("btn1_glitch", act_glitch, 16'h0001);
        // "h" then "i" back to back
        add_row("bp_pair", act_pair, 16'h6869);
        // "x" is echoed, "y" arrives behind a pending star
        add_row("bp_drop", act_drop, 16'h7879);
    endtask

    // Reference model of the echo rules
    task automatic predict_byte(input logic [7:0] b);
        rx_word_u w;
        w.ascii = b;
        if (w.cmd.is_cmd || model_sw[1]) begin
            model_leds = w.cmd.led_value;
        end else if (model_sw[0] && is_letter(w.ascii)) begin
            exp_q.push_back(w.ascii ^ (8'd1 << case_bit));
        end else begin
            exp_q.push_back(w.ascii);
        end
    endtask

    task automatic predict(input stim_t row);
        case (row.action)
            act_send: predict_byte(row.value[7:0]);
            act_pair: begin
                predict_byte(row.value[15:8]);
                predict_byte(row.value[7:0]);
            end
            act_press: begin
                if (row.value == 16'd1) begin
                    exp_q.push_back(char_star);
                end else if (row.value == 16'd0) begin
                    model_leds = '0;
                end
            end
            act_switch: model_sw = row.value[1:0];
            // The byte behind the pending star is dropped
            act_drop: begin
                predict_byte(row.value[15:8]);
                exp_q.push_back(char_star);
            end
            default: ;
        endcase
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge cpu_clk);
            serial_rx = frame[i];
            repeat (bit_cycles - 1) @(negedge cpu_clk);
        end
    endtask

    task automatic hold_button(input int idx, input int len);
        @(negedge cpu_clk);
        buttons[idx] = 1'b1;
        repeat (len) @(negedge cpu_clk);
        buttons[idx] = 1'b0;
    endtask

    task automatic wait_line_low(input int max_wait, output bit seen);
        int waited;
        waited = 0;
        @(negedge cpu_clk);
        while (serial_tx !== 1'b0 && waited < max_wait) begin
            @(negedge cpu_clk);
            waited++;
        end
        seen = (serial_tx === 1'b0);
    endtask

    task automatic get_frame(output logic [7:0] data, output bit ok);
        bit   seen;
        logic stop_bit;
        data = '0;
        ok = 1'b0;
        wait_line_low(frame_wait, seen);
        if (!seen) begin
            return;
        end
        // Middle of the start bit
        repeat (bit_cycles / 2) @(negedge cpu_clk);
        if (serial_tx !== 1'b0) begin
            return;
        end
        for (int i = 0; i < data_width; i++) begin
            repeat (bit_cycles) @(negedge cpu_clk);
            data[i] = serial_tx;
        end
        repeat (bit_cycles) @(negedge cpu_clk);
        stop_bit = serial_tx;
        ok = (stop_bit === 1'b1);
    endtask

    task automatic collect_frames(input int count);
        logic [7:0] b;
        bit         ok;
        for (int i = 0; i < count; i++) begin
            get_frame(b, ok);
            if (!ok) begin
                break;
            end
            got_q.push_back(b);
        end
    endtask

    task automatic watch_quiet(input int len, output bit quiet);
        quiet = 1'b1;
        repeat (len) begin
            @(negedge cpu_clk);
            if (serial_tx !== 1'b1) begin
                quiet = 1'b0;
            end
        end
    endtask

    task automatic apply_action(input stim_t row);
        bit seen;
        case (row.action)
            act_send: send_byte(row.value[7:0]);
            act_pair: begin
                send_byte(row.value[15:8]);
                send_byte(row.value[7:0]);
            end
            act_press: hold_button(int'(row.value[1:0]), press_cycles);
            act_glitch: hold_button(int'(row.value[1:0]), glitch_cycles);
            act_switch: begin
                @(negedge cpu_clk);
                switches = row.value[1:0];
                repeat (4) @(negedge cpu_clk);
            end
            act_drop: begin
                // Star press lands while the first echo is on the line
                fork
                    begin
                        send_byte(row.value[15:8]);
                        send_byte(row.value[7:0]);
                    end
                    begin
                        wait_line_low(frame_wait, seen);
                        hold_button(1, (pulse_cnt + 1) * sample_cnt);
                    end
                join
            end
            default: ;
        endcase
    endtask

    task automatic run_row(input stim_t row);
        int errors_before;
        int n_exp;
        bit quiet;
        errors_before = errors;
        exp_q.delete();
        got_q.delete();
        predict(row);
        n_exp = exp_q.size();
        fork
            apply_action(row);
            collect_frames(n_exp);
        join
        watch_quiet(quiet_cycles, quiet);
        assert (got_q.size() == n_exp) else begin
            $display("ERROR %s: only %0d of %0d expected serial bytes arrived",
                     row.name, got_q.size(), n_exp);
            errors++;
        end
        for (int i = 0; i < got_q.size(); i++) begin
            assert (got_q[i] == exp_q[i]) else begin
                $display("MISMATCH %s byte %0d expected %02h actual %02h",
                         row.name, i, exp_q[i], got_q[i]);
                errors++;
            end
        end
        assert (quiet) else begin
            $display("ERROR %s: serial output appeared when no byte was expected", row.name);
            errors++;
        end
        assert (leds === model_leds) else begin
            $display("MISMATCH %s LEDS expected %02h actual %02h", row.name, model_leds, leds);
            errors++;
        end
        if (errors == errors_before) begin
            $display("%s: pass", row.name);
        end else begin
            $display("%s: FAIL", row.name);
            tests_failed++;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        buttons = '0;
        switches = '0;
        serial_rx = 1'b1;
        model_leds = '0;
        model_sw = '0;
        void'($urandom(32'hca06));
        build_table();
        cycle_limit = rows.size() * row_budget + 10 * frame_cycles;
        repeat (4) @(posedge cpu_clk);
        @(negedge cpu_clk);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("tests %0d failed %0d check errors %0d", rows.size(), tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== z1top.f ====
z1top_pkg.sv
tick_timer.sv
button_parser.sv
uart_receiver.sv
uart_transmitter.sv
echo_controller.sv
z1top.sv
z1top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= z1top.f
TB_TOP    ?= z1top_tb
DUT_TOP   ?= z1top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
